// ==== Bender.yml ====
package:
  name: aes_ctr_sub

sources:
  - include_dirs:
      - common
    files:
      - common/aes_ctr_pkg.sv
      - design/aes_sp2v_chk.sv
      - aes_ctr/aes_ctr_fsm.sv
      - aes_ctr/aes_ctr.sv
      - design/aes_ctr_reg.sv
      - design/aes_ctr_top.sv

  - target: test
    include_dirs:
      - common
    files:
      - verif/aes_ctr_tb.sv

// ==== aes_ctr/aes_ctr.sv ====
////////////////////////////////////////
// CTR control with request check, redundant
// rails, rail compare and write-enable fan-out
////////////////////////////////////////

`timescale 1ns/100ps

`include "aes_ctr_settings.svh"

module aes_ctr (
  input  logic                 clk_i,
  input  logic                 rst_n_i,

  // Sparse request and status
  input  aes_ctr_pkg::sp2v_e   incr_i,
  output aes_ctr_pkg::sp2v_e   ready_o,
  output logic                 alert_o,

  // Current counter and write bundle to the store
  input  aes_ctr_pkg::ctr_t    ctr_i,
  output aes_ctr_pkg::ctr_wr_t ctr_wr_o
);

  // Byte order swap, big-endian to numeric and back
  function automatic aes_ctr_pkg::ctr_t rev_bytes(aes_ctr_pkg::ctr_t in);
    aes_ctr_pkg::ctr_t out;
    for (int i = 0; i < aes_ctr_pkg::CtrBytes; i++) begin
      out[i] = in[aes_ctr_pkg::CtrBytes-1-i];
    end
    return out;
  endfunction

  // Slice order swap of the enables
  function automatic aes_ctr_pkg::sp2v_e [`AES_CTR_NUM_SLICES-1:0] rev_sp2v(
      aes_ctr_pkg::sp2v_e [`AES_CTR_NUM_SLICES-1:0] in);
    aes_ctr_pkg::sp2v_e [`AES_CTR_NUM_SLICES-1:0] out;
    for (int i = 0; i < `AES_CTR_NUM_SLICES; i++) begin
      out[i] = in[`AES_CTR_NUM_SLICES-1-i];
    end
    return out;
  endfunction

  // Rail polarity pattern
  localparam logic [`AES_CTR_SP2V_WIDTH-1:0] RailPol = aes_ctr_pkg::SP2V_HIGH;

  aes_ctr_pkg::ctr_slices_t                     ctr_i_rev;
  aes_ctr_pkg::ctr_slices_t                     ctr_o_rev;
  aes_ctr_pkg::slice_t                          slice_in;
  aes_ctr_pkg::sp2v_e [`AES_CTR_NUM_SLICES-1:0] we_rev;
  aes_ctr_pkg::sp2v_e                           we;

  aes_ctr_pkg::sp2v_e                           incr;
  logic                                         incr_err;
  logic                                         mr_err;

  // One bit per rail
  logic [`AES_CTR_SP2V_WIDTH-1:0]               sp_incr;
  logic [`AES_CTR_SP2V_WIDTH-1:0]               sp_ready;
  logic [`AES_CTR_SP2V_WIDTH-1:0]               sp_we;

  // Per-rail outputs and their OR
  aes_ctr_pkg::rail_out_t [`AES_CTR_SP2V_WIDTH-1:0] mr_rail;
  aes_ctr_pkg::rail_out_t                           rail;

  ////////////////////////////////////////
  // Inputs
  ////////////////////////////////////////

  // Numeric view, slice 0 least significant
  assign ctr_i_rev = rev_bytes(ctr_i);

  // Request passes one register stage
  aes_sp2v_chk u_incr_chk (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .sp_i    (incr_i),
    .sp_o    (incr),
    .err_o   (incr_err)
  );

  assign sp_incr  = incr;
  assign slice_in = ctr_i_rev[rail.idx];

  ////////////////////////////////////////
  // Redundant rails
  ////////////////////////////////////////

  for (genvar i = 0; i < `AES_CTR_SP2V_WIDTH; i++) begin : gen_rail
    aes_ctr_fsm #(
      .RailActiveHigh (RailPol[i])
    ) u_rail (
      .clk_i      (clk_i),
      .rst_n_i    (rst_n_i),
      .incr_i     (sp_incr[i]),
      .ready_o    (sp_ready[i]),
      .we_o       (sp_we[i]),
      .incr_err_i (incr_err),
      .mr_err_i   (mr_err),
      .slice_i    (slice_in),
      .rail_o     (mr_rail[i])
    );
  end

  // Sparse pins back to codes
  assign ready_o = aes_ctr_pkg::sp2v_e'(sp_ready);
  assign we      = aes_ctr_pkg::sp2v_e'(sp_we);

  // OR of all rails, then each rail must equal it
  always_comb begin
    rail   = '0;
    mr_err = 1'b0;
    for (int i = 0; i < `AES_CTR_SP2V_WIDTH; i++) begin
      rail = rail | mr_rail[i];
    end
    for (int i = 0; i < `AES_CTR_SP2V_WIDTH; i++) begin
      if (rail.idx != mr_rail[i].idx || rail.slice != mr_rail[i].slice) begin
        mr_err = 1'b1;
      end
    end
  end

  // Any rail alert is enough
  assign alert_o = rail.alert;

  ////////////////////////////////////////
  // Outputs
  ////////////////////////////////////////

  // New slice into the counter, enable on the same slice only
  always_comb begin
    ctr_o_rev           = ctr_i_rev;
    ctr_o_rev[rail.idx] = rail.slice;
    for (int i = 0; i < `AES_CTR_NUM_SLICES; i++) begin
      we_rev[i] = aes_ctr_pkg::SP2V_LOW;
    end
    we_rev[rail.idx] = we;
  end

  // Back to big-endian order
  assign ctr_wr_o.ctr = rev_bytes(ctr_o_rev);
  assign ctr_wr_o.we  = rev_sp2v(we_rev);

endmodule

// ==== aes_ctr/aes_ctr_fsm.sv ====
////////////////////////////////////////
// Single FSM rail of the slice-wise counter
////////////////////////////////////////

`timescale 1ns/100ps

`include "aes_ctr_settings.svh"

module aes_ctr_fsm #(
  // Polarity of the sparse pins on this rail
  parameter bit RailActiveHigh = 1'b1
) (
  input  logic                   clk_i,
  input  logic                   rst_n_i,

  // Sparse pins, inverted on an active-low rail
  input  logic                   incr_i,
  output logic                   ready_o,
  output logic                   we_o,

  // Request error and rail mismatch error
  input  logic                   incr_err_i,
  input  logic                   mr_err_i,

  // Current slice in, index, new slice and alert out
  input  aes_ctr_pkg::slice_t    slice_i,
  output aes_ctr_pkg::rail_out_t rail_o
);

  // Onehot state codes
  typedef enum logic [2:0] {
    CTR_IDLE  = 3'b001,
    CTR_INCR  = 3'b010,
    CTR_ERROR = 3'b100
  } ctr_state_e;

  localparam aes_ctr_pkg::slice_idx_t LastIdx =
      aes_ctr_pkg::slice_idx_t'(`AES_CTR_NUM_SLICES - 1);

  ctr_state_e                    state_q, state_d;
  aes_ctr_pkg::slice_idx_t       idx_q, idx_d;
  logic                          carry_q, carry_d;
  logic [`AES_CTR_SLICE_SIZE:0]  sum;

  // Rail-local active-high views of the pins
  logic                          incr;
  logic                          ready;
  logic                          we;
  logic                          alert;

  ////////////////////////////////////////
  // Pin polarity
  ////////////////////////////////////////

  assign incr    = RailActiveHigh ? incr_i : ~incr_i;
  assign ready_o = RailActiveHigh ? ready  : ~ready;
  assign we_o    = RailActiveHigh ? we     : ~we;

  // Slice adder, top bit is the carry out
  assign sum = {1'b0, slice_i} + {{`AES_CTR_SLICE_SIZE{1'b0}}, carry_q};

  ////////////////////////////////////////
  // Next state
  ////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    idx_d   = idx_q;
    carry_d = carry_q;
    ready   = 1'b0;
    we      = 1'b0;
    alert   = 1'b0;

    unique case (state_q)
      CTR_IDLE: begin
        ready = 1'b1;
        // Start at the least significant slice, carry in of one
        if (incr) begin
          state_d = CTR_INCR;
          idx_d   = '0;
          carry_d = 1'b1;
        end
      end
      CTR_INCR: begin
        // Every slice is written, constant walk length
        we      = 1'b1;
        carry_d = sum[`AES_CTR_SLICE_SIZE];
        idx_d   = idx_q + 1'b1;
        if (idx_q == LastIdx) begin
          state_d = CTR_IDLE;
        end
      end
      CTR_ERROR: begin
        // Terminal, only reset leaves
        alert = 1'b1;
      end
      default: begin
        state_d = CTR_ERROR;
      end
    endcase

    // Any error parks the rail
    if (incr_err_i || mr_err_i) begin
      state_d = CTR_ERROR;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= CTR_IDLE;
      idx_q   <= '0;
      carry_q <= 1'b0;
    end else begin
      state_q <= state_d;
      idx_q   <= idx_d;
      carry_q <= carry_d;
    end
  end

  // Multi-bit outputs, combined in the control module
  assign rail_o.idx   = idx_q;
  assign rail_o.slice = sum[`AES_CTR_SLICE_SIZE-1:0];
  assign rail_o.alert = alert;

endmodule

// ==== aes_ctr_sub.f ====
+incdir+common
common/aes_ctr_pkg.sv
design/aes_sp2v_chk.sv
aes_ctr/aes_ctr_fsm.sv
aes_ctr/aes_ctr.sv
design/aes_ctr_reg.sv
design/aes_ctr_top.sv
verif/aes_ctr_tb.sv

// ==== common/aes_ctr_pkg.sv ====
////////////////////////////////////////
// Sparse code, slice types and shared structs
// of the CTR counter unit
////////////////////////////////////////

package aes_ctr_pkg;

  `include "aes_ctr_settings.svh"

  // Bytes in the full counter
  localparam int unsigned CtrBytes = `AES_CTR_NUM_SLICES * `AES_CTR_SLICE_SIZE / 8;

  ////////////////////////////////////////
  // Sparse two-value encoding
  ////////////////////////////////////////

  // Only these two codes are legal, all others are errors
  // Bit i of SP2V_HIGH sets the polarity of rail i
  typedef enum logic [`AES_CTR_SP2V_WIDTH-1:0] {
    SP2V_HIGH = 3'b011,
    SP2V_LOW  = 3'b100
  } sp2v_e;

  ////////////////////////////////////////
  // Counter views
  ////////////////////////////////////////

  // Index of one slice, slice 0 least significant
  typedef logic [$clog2(`AES_CTR_NUM_SLICES)-1:0] slice_idx_t;

  // One slice of the counter
  typedef logic [`AES_CTR_SLICE_SIZE-1:0] slice_t;

  // Full counter, big-endian
  // Byte 0 holds the most significant counter byte
  typedef logic [CtrBytes-1:0][7:0] ctr_t;

  // Same 128 bits seen as slices
  typedef slice_t [`AES_CTR_NUM_SLICES-1:0] ctr_slices_t;

  ////////////////////////////////////////
  // Shared structs
  ////////////////////////////////////////

  // Multi-bit output of one rail
  // OR-combined and compared across rails
  typedef struct packed {
    slice_idx_t idx;
    slice_t     slice;
    logic       alert;
  } rail_out_t;

  // Write bundle from control to counter store
  // Enable j belongs to slice j of the ctr_t vector
  typedef struct packed {
    sp2v_e [`AES_CTR_NUM_SLICES-1:0] we;
    ctr_t                            ctr;
  } ctr_wr_t;

endpackage

// ==== common/aes_ctr_settings.svh ====
////////////////////////////////////////
// Counter geometry and sparse code width
////////////////////////////////////////

`ifndef AES_CTR_SETTINGS_SVH
`define AES_CTR_SETTINGS_SVH

// Number of slices the increment walks
`define AES_CTR_NUM_SLICES 8

// Bits per slice, one adder of this width per rail
`define AES_CTR_SLICE_SIZE 16

// Width of the sparse two-value code
// Also the number of redundant FSM rails
`define AES_CTR_SP2V_WIDTH 3

`endif

// ==== design/aes_ctr_reg.sv ====
////////////////////////////////////////
// Counter store with load and sparse slice writes
////////////////////////////////////////

`timescale 1ns/100ps

`include "aes_ctr_settings.svh"

module aes_ctr_reg (
  input  logic                 clk_i,
  input  logic                 rst_n_i,

  // Load of the initial value
  input  logic                 ld_i,
  input  aes_ctr_pkg::ctr_t    iv_i,

  // Slice writes from the control module
  input  aes_ctr_pkg::ctr_wr_t ctr_wr_i,

  output aes_ctr_pkg::ctr_t    ctr_o,
  output logic                 err_o
);

  aes_ctr_pkg::ctr_slices_t ctr_q;
  aes_ctr_pkg::ctr_slices_t iv_slices;
  aes_ctr_pkg::ctr_slices_t wr_slices;
  logic                     we_err;
  logic                     err_q;

  // Slice views of the incoming values
  assign iv_slices = iv_i;
  assign wr_slices = ctr_wr_i.ctr;

  ////////////////////////////////////////
  // Slice registers
  ////////////////////////////////////////

  // Load wins over any slice write
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ctr_q <= '0;
    end else if (ld_i) begin
      ctr_q <= iv_slices;
    end else begin
      for (int j = 0; j < `AES_CTR_NUM_SLICES; j++) begin
        if (ctr_wr_i.we[j] == aes_ctr_pkg::SP2V_HIGH) begin
          ctr_q[j] <= wr_slices[j];
        end
      end
    end
  end

  assign ctr_o = ctr_q;

  ////////////////////////////////////////
  // Enable check
  ////////////////////////////////////////

  always_comb begin
    we_err = 1'b0;
    for (int j = 0; j < `AES_CTR_NUM_SLICES; j++) begin
      if (ctr_wr_i.we[j] != aes_ctr_pkg::SP2V_HIGH &&
          ctr_wr_i.we[j] != aes_ctr_pkg::SP2V_LOW) begin
        we_err = 1'b1;
      end
    end
  end

  // Sticky until reset
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      err_q <= 1'b0;
    end else if (we_err) begin
      err_q <= 1'b1;
    end
  end

  assign err_o = err_q;

endmodule

// ==== design/aes_ctr_top.sv ====
////////////////////////////////////////
// Top level, control plus counter store
////////////////////////////////////////

`timescale 1ns/100ps

module aes_ctr_top (
  input  logic               clk_i,
  input  logic               rst_n_i,

  // Load port
  input  logic               ld_i,
  input  aes_ctr_pkg::ctr_t  iv_i,

  // Sparse increment handshake
  input  aes_ctr_pkg::sp2v_e incr_i,
  output aes_ctr_pkg::sp2v_e ready_o,

  output aes_ctr_pkg::ctr_t  ctr_o,
  output logic               alert_o
);

  aes_ctr_pkg::ctr_t    ctr;
  aes_ctr_pkg::ctr_wr_t ctr_wr;
  logic                 ctr_alert;
  logic                 reg_err;

  // Control reads back the stored counter
  aes_ctr u_ctr (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .incr_i   (incr_i),
    .ready_o  (ready_o),
    .alert_o  (ctr_alert),
    .ctr_i    (ctr),
    .ctr_wr_o (ctr_wr)
  );

  aes_ctr_reg u_reg (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .ld_i     (ld_i),
    .iv_i     (iv_i),
    .ctr_wr_i (ctr_wr),
    .ctr_o    (ctr),
    .err_o    (reg_err)
  );

  assign ctr_o = ctr;

  // Either source raises the alert
  assign alert_o = ctr_alert | reg_err;

endmodule

// ==== design/aes_sp2v_chk.sv ====
////////////////////////////////////////
// Registered sparse code checker
////////////////////////////////////////

`timescale 1ns/100ps

module aes_sp2v_chk (
  input  logic               clk_i,
  input  logic               rst_n_i,

  // Raw sparse input
  input  aes_ctr_pkg::sp2v_e sp_i,

  // Registered copy and encoding error
  output aes_ctr_pkg::sp2v_e sp_o,
  output logic               err_o
);

  aes_ctr_pkg::sp2v_e sp_q;

  // One register stage on the sparse value
  // Idles at the inactive code
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      sp_q <= aes_ctr_pkg::SP2V_LOW;
    end else begin
      sp_q <= sp_i;
    end
  end

  assign sp_o = sp_q;

  // Error on any code other than the two legal ones
  always_comb begin
    err_o = 1'b1;
    if (sp_q == aes_ctr_pkg::SP2V_HIGH) begin
      err_o = 1'b0;
    end
    if (sp_q == aes_ctr_pkg::SP2V_LOW) begin
      err_o = 1'b0;
    end
  end

endmodule

// ==== verif/aes_ctr_tb.sv ====
////////////////////////////////////////
// Table-driven testbench of the CTR counter unit
////////////////////////////////////////

`timescale 1ns/100ps

module aes_ctr_tb;

  localparam int unsigned NumSteps     = 13;
  localparam int unsigned NumRandom    = 6;
  localparam int unsigned ReadyTimeout = 24;
  localparam int unsigned AlertTimeout = 2;

  // Neither of the two legal sparse codes
  localparam logic [2:0]  BadCode      = 3'b110;

  typedef enum logic [1:0] {
    OP_LOAD,
    OP_INCR,
    OP_BAD
  } op_e;

  // One table row
  // Value holds the plain numeric counter value
  typedef struct packed {
    op_e          op;
    logic [127:0] value;
    logic [7:0]   count;
    logic         alert;
  } step_t;

  logic               clk;
  logic               rst_n;
  logic               ld;
  aes_ctr_pkg::ctr_t  iv;
  aes_ctr_pkg::sp2v_e incr;
  aes_ctr_pkg::sp2v_e ready;
  aes_ctr_pkg::ctr_t  ctr;
  logic               alert;

  step_t              steps [NumSteps];
  aes_ctr_pkg::ctr_t  model;
  logic [127:0]       rnd;
  integer             seed;

  aes_ctr_top dut_i (
    .clk_i   (clk),
    .rst_n_i (rst_n),
    .ld_i    (ld),
    .iv_i    (iv),
    .incr_i  (incr),
    .ready_o (ready),
    .ctr_o   (ctr),
    .alert_o (alert)
  );

  // 4 ns clock
  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  ////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////

  // Numeric value to big-endian bytes with byte 0 on top
  function automatic aes_ctr_pkg::ctr_t to_ctr(logic [127:0] num);
    aes_ctr_pkg::ctr_t res;
    for (int i = 0; i < aes_ctr_pkg::CtrBytes; i++) begin
      res[i] = num[127-8*i -: 8];
    end
    return res;
  endfunction

  // Plus one mod 2^128 rippling up from the last byte
  function automatic aes_ctr_pkg::ctr_t add_one(aes_ctr_pkg::ctr_t val);
    aes_ctr_pkg::ctr_t res;
    logic [8:0]        acc;
    logic              carry;
    carry = 1'b1;
    for (int i = aes_ctr_pkg::CtrBytes - 1; i >= 0; i--) begin
      acc    = {1'b0, val[i]} + {8'd0, carry};
      res[i] = acc[7:0];
      carry  = acc[8];
    end
    return res;
  endfunction

  ////////////////////////////////////////
  // Checks
  ////////////////////////////////////////

  task automatic report_error(input string msg);
    $display("%s", msg);
    $display(">>> FAIL");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_ctr(input string name, input aes_ctr_pkg::ctr_t exp,
                           input aes_ctr_pkg::ctr_t act);
    if (act !== exp) begin
      report_error($sformatf("Fail %0t %s expected %h got %h", $time, name, exp, act));
    end
  endtask

  task automatic check_sp2v(input string name, input aes_ctr_pkg::sp2v_e exp,
                            input aes_ctr_pkg::sp2v_e act);
    if (act !== exp) begin
      report_error($sformatf("Fail %0t %s expected %b got %b", $time, name, exp, act));
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      report_error($sformatf("Fail %0t %s expected %b got %b", $time, name, exp, act));
    end
  endtask

  // Idle state right after reset
  task automatic check_reset_state();
    check_sp2v("ready_o", aes_ctr_pkg::SP2V_HIGH, ready);
    check_bit("alert_o", 1'b0, alert);
    check_ctr("ctr_o", '0, ctr);
  endtask

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////

  task automatic apply_reset();
    @(posedge clk);
    rst_n <= 1'b0;
    ld    <= 1'b0;
    incr  <= aes_ctr_pkg::SP2V_LOW;
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
  endtask

  // One-cycle load strobe
  task automatic load_value(input aes_ctr_pkg::ctr_t val);
    @(posedge clk);
    ld <= 1'b1;
    iv <= val;
    @(posedge clk);
    ld <= 1'b0;
    @(negedge clk);
  endtask

  // Request for one cycle then wait for the walk to start and end
  task automatic request_incr();
    int unsigned waited;
    @(posedge clk);
    incr <= aes_ctr_pkg::SP2V_HIGH;
    @(posedge clk);
    incr <= aes_ctr_pkg::SP2V_LOW;
    waited = 0;
    @(negedge clk);
    while (ready == aes_ctr_pkg::SP2V_HIGH) begin
      waited++;
      if (waited > ReadyTimeout) begin
        report_error("Timeout: ready_o never left the idle code after a request");
      end
      @(negedge clk);
    end
    waited = 0;
    while (ready != aes_ctr_pkg::SP2V_HIGH) begin
      // No rail mismatch while walking
      check_bit("alert_o", 1'b0, alert);
      if (ready != aes_ctr_pkg::SP2V_LOW) begin
        report_error("ready_o showed an illegal sparse code during the walk");
      end
      waited++;
      if (waited > ReadyTimeout) begin
        report_error("Timeout: ready_o did not return to the idle code");
      end
      @(negedge clk);
    end
  endtask

  // Illegal code for one cycle then wait for the alert
  task automatic request_bad();
    int unsigned waited;
    @(posedge clk);
    incr <= aes_ctr_pkg::sp2v_e'(BadCode);
    @(posedge clk);
    incr <= aes_ctr_pkg::SP2V_LOW;
    waited = 0;
    @(negedge clk);
    while (alert !== 1'b1) begin
      waited++;
      if (waited > AlertTimeout) begin
        report_error("Timeout: alert_o never rose after an invalid request code");
      end
      @(negedge clk);
    end
  endtask

  task automatic set_step(input int idx, input op_e op, input logic [127:0] value,
                          input logic [7:0] count, input logic alert_exp);
    steps[idx].op    = op;
    steps[idx].value = value;
    steps[idx].count = count;
    steps[idx].alert = alert_exp;
  endtask

  // Small value, slice and byte carries, wrap, bad code, restart
  task automatic fill_table();
    set_step(0, OP_LOAD, 128'h5, 0, 1'b0);
    set_step(1, OP_INCR, '0, 1, 1'b0);
    set_step(2, OP_LOAD, 128'h0000_0000_0000_0000_0000_0000_FFFF_FFFF, 0, 1'b0);
    set_step(3, OP_INCR, '0, 1, 1'b0);
    set_step(4, OP_LOAD, 128'h00FF_FFFF_FFFF_FFFF_FFFF_FFFF_FFFF_FFFE, 0, 1'b0);
    set_step(5, OP_INCR, '0, 2, 1'b0);
    set_step(6, OP_LOAD, 128'h0123_4567_89AB_CDEF_0011_2233_4455_66FF, 0, 1'b0);
    set_step(7, OP_INCR, '0, 1, 1'b0);
    set_step(8, OP_LOAD, {128{1'b1}}, 0, 1'b0);
    set_step(9, OP_INCR, '0, 3, 1'b0);
    set_step(10, OP_BAD, '0, 0, 1'b1);
    set_step(11, OP_LOAD, 128'h0000_0000_0000_0000_0000_0000_0000_FFFF, 0, 1'b0);
    set_step(12, OP_INCR, '0, 1, 1'b0);
  endtask

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////

  initial begin
    rst_n  = 1'b0;
    ld     = 1'b0;
    iv     = '0;
    incr   = aes_ctr_pkg::SP2V_LOW;
    seed   = 32'hff9a;
    model  = '0;
    fill_table();

    apply_reset();
    check_reset_state();

    for (int i = 0; i < NumSteps; i++) begin
      case (steps[i].op)
        OP_LOAD: begin
          model = to_ctr(steps[i].value);
          load_value(model);
          check_ctr("ctr_o", model, ctr);
          check_bit("alert_o", steps[i].alert, alert);
        end
        OP_INCR: begin
          for (int n = 0; n < steps[i].count; n++) begin
            request_incr();
            model = add_one(model);
            check_ctr("ctr_o", model, ctr);
          end
          check_bit("alert_o", steps[i].alert, alert);
        end
        default: begin
          request_bad();
          check_sp2v("ready_o", aes_ctr_pkg::SP2V_LOW, ready);
          check_ctr("ctr_o", model, ctr);
          // Alert is sticky and the counter stays put
          repeat (3) @(negedge clk);
          check_bit("alert_o", steps[i].alert, alert);
          check_sp2v("ready_o", aes_ctr_pkg::SP2V_LOW, ready);
          check_ctr("ctr_o", model, ctr);
          apply_reset();
          model = '0;
          check_reset_state();
        end
      endcase
    end

    // Random values with the low slices forced to ones on odd rounds
    for (int n = 0; n < NumRandom; n++) begin
      rnd = {$random(seed), $random(seed), $random(seed), $random(seed)};
      if (n % 2 == 1) begin
        rnd[31:0] = '1;
      end
      model = to_ctr(rnd);
      load_value(model);
      check_ctr("ctr_o", model, ctr);
      repeat (2) begin
        request_incr();
        model = add_one(model);
        check_ctr("ctr_o", model, ctr);
        check_bit("alert_o", 1'b0, alert);
      end
    end

    $display(">>> PASS");
    $finish;
  end

endmodule
